// ==== list.f ====
fetch_pkg.sv
fetch_ctrl_if.sv
instr_decompressor.sv
fetch_aligner.sv
fetch_address_gen.sv
fetch_unit_top.sv
tb_fetch_mem.sv
tb_fetch_unit.sv

// ==== tb_fetch_unit.sv ====
module tb_fetch_unit;

    import fetch_pkg::*;

    localparam int          MEM_WORDS   = 64;
    localparam int          MAX_EXP     = 256;
    localparam int          TOTAL_INSTR = 320;
    // Step, request, up to five cycles of ack wait, release and the next step
    localparam int          READ_CYCLES = 10;
    localparam int          CYCLE_LIMIT = 10 * TOTAL_INSTR * READ_CYCLES;
    localparam logic [31:0] SEED        = 32'h65bb_c0cd;
    localparam addr_t       RESET_PC    = 32'h0000_0000;

    logic        clk_i;
    logic        rst_i;
    logic        stall_i;
    logic        branch_i;
    addr_t       branch_target_i;
    logic        mem_req_o;
    word_addr_t  mem_addr_o;
    logic        mem_ack_i;
    logic [31:0] mem_data_i;
    instr_t      instr_o;
    logic        instr_valid_o;
    addr_t       pc_o;

    // Expected stream of the current segment starting at reset or the last branch
    addr_t       exp_pc [MAX_EXP];
    instr_t      exp_instr [MAX_EXP];
    int          seg_idx;
    int          checked;
    int          errors;
    int          stall_pct;
    logic        first_ack_seen;
    logic        first_read_done;

    fetch_unit_top uut (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .stall_i         (stall_i),
        .branch_i        (branch_i),
        .branch_target_i (branch_target_i),
        .mem_req_o       (mem_req_o),
        .mem_addr_o      (mem_addr_o),
        .mem_ack_i       (mem_ack_i),
        .mem_data_i      (mem_data_i),
        .instr_o         (instr_o),
        .instr_valid_o   (instr_valid_o),
        .pc_o            (pc_o)
    );

    tb_fetch_mem #(
        .DEPTH (MEM_WORDS)
    ) u_mem (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .req_i  (mem_req_o),
        .addr_i (mem_addr_o),
        .ack_o  (mem_ack_i),
        .data_o (mem_data_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    //////////////////////////////
    // Program image
    //////////////////////////////

    task automatic put_parcel(input int p, input parcel_t value);
        int w;
        w = (p / 2) % MEM_WORDS;
        if (p % 2 == 1) begin
            u_mem.prog[w][31:16] = value;
        end else begin
            u_mem.prog[w][15:0] = value;
        end
    endtask

    function automatic parcel_t parcel_at(input logic [31:0] half_idx);
        int w;
        w = (half_idx >> 1) % MEM_WORDS;
        return half_idx[0] ? u_mem.prog[w][31:16] : u_mem.prog[w][15:0];
    endfunction

    // Kind 1 is from the subset, kind 2 is any non-32-bit parcel
    function automatic parcel_t random_parcel(input int kind);
        logic [4:0] rd;
        logic [4:0] rs2;
        logic [5:0] imm;
        parcel_t    v;
        rd  = 5'($urandom);
        rs2 = 5'($urandom % 31 + 1);
        imm = 6'($urandom);
        v   = parcel_t'($urandom);
        if (kind == 1) begin
            case ($urandom % 6)
                0: v = 16'h0001;
                1: v = {3'b000, imm[5], rd, imm[4:0], 2'b01};
                2: v = {3'b010, imm[5], rd, imm[4:0], 2'b01};
                3: v = {3'b011, imm[5], rd, imm[4:0], 2'b01};
                4: v = {4'b1000, rd, rs2, 2'b10};
                default: v = {4'b1001, rd, rs2, 2'b10};
            endcase
        end else if (v[1:0] == 2'b11) begin
            v[1:0] = 2'b00;
        end
        return v;
    endfunction

    // Parcels 0 to 31 hold 32-bit instructions, 32 to 63 compressed ones, the rest a mix
    task automatic fill_program();
        int p;
        int kind;
        p = 0;
        while (p < 2 * MEM_WORDS) begin
            if (p < 32) begin
                kind = 0;
            end else if (p < 64 || p == 2 * MEM_WORDS - 1) begin
                kind = 1 + ($urandom % 2);
            end else begin
                kind = $urandom % 3;
            end
            if (kind == 0) begin
                put_parcel(p, parcel_t'($urandom) | 16'h0003);
                put_parcel(p + 1, parcel_t'($urandom));
                p = p + 2;
            end else begin
                put_parcel(p, random_parcel(kind));
                p = p + 1;
            end
        end
        // Word 40 gets a 32-bit instruction in its upper half that straddles into word 41
        u_mem.prog[40][17:16] = 2'b11;
    endtask

    //////////////////////////////
    // Reference model
    //////////////////////////////

    function automatic instr_t expand_ref(input parcel_t c);
        logic [31:0] full;
        logic [4:0]  rd;
        logic [4:0]  rs2;
        logic [11:0] imm;
        rd   = c[11:7];
        rs2  = c[6:2];
        imm  = {{7{c[12]}}, c[6:2]};
        full = 32'h0;
        if (c[1:0] == 2'b01 && c[15:13] == 3'b000) begin
            full = {imm, rd, 3'b000, rd, 7'h13};
        end else if (c[1:0] == 2'b01 && c[15:13] == 3'b010) begin
            full = {imm, 5'd0, 3'b000, rd, 7'h13};
        end else if (c[1:0] == 2'b01 && c[15:13] == 3'b011 && rd != 5'd2 && imm != 12'd0) begin
            full = {{8{imm[11]}}, imm, rd, 7'h37};
        end else if (c[1:0] == 2'b10 && c[15:13] == 3'b100 && rs2 != 5'd0) begin
            // C.ADD keeps rd as rs1 while C.MV reads x0
            full = {7'd0, rs2, c[12] ? rd : 5'd0, 3'b000, rd, 7'h33};
        end
        return full[31:2];
    endfunction

    function automatic void walk_ref(input addr_t start);
        addr_t   pc;
        parcel_t lo;
        int      i;
        pc = start;
        for (i = 0; i < MAX_EXP; i++) begin
            lo        = parcel_at(pc >> 1);
            exp_pc[i] = pc;
            if (lo[1:0] == 2'b11) begin
                exp_instr[i] = {parcel_at((pc >> 1) + 1), lo[15:2]};
                pc           = pc + 4;
            end else begin
                exp_instr[i] = expand_ref(lo);
                pc           = pc + 2;
            end
        end
    endfunction

    //////////////////////////////
    // Comparison
    //////////////////////////////

    // Outputs settle after the rising edge so they are sampled on the falling one
    always @(negedge clk_i) begin
        if (rst_i) begin
            if (instr_valid_o) begin
                if (!first_read_done) begin
                    $display("Valid output at %0t before the first read completed", $time);
                    errors++;
                end
                if (seg_idx >= MAX_EXP) begin
                    $display("More instructions at %0t than the reference holds", $time);
                    errors++;
                end else if (pc_o !== exp_pc[seg_idx] || instr_o !== exp_instr[seg_idx]) begin
                    $display("Fail at %0t: pc exp %h seen %h, instr exp %h seen %h", $time,
                             exp_pc[seg_idx], pc_o, exp_instr[seg_idx], instr_o);
                    errors++;
                end
                seg_idx++;
                checked++;
            end
            // The first read ends when memory has acked and released again
            if (mem_ack_i) begin
                first_ack_seen = 1'b1;
            end else if (first_ack_seen) begin
                first_read_done = 1'b1;
            end
        end
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    // Runs one clock cycle and reports whether its rising edge was a step
    task automatic advance_cycle(output logic stepped);
        @(negedge clk_i);
        stepped = !uut.ctrl_if.busywait && !stall_i;
        @(posedge clk_i);
        #1;
        stall_i = (($urandom % 100) < stall_pct);
    endtask

    task automatic run_until(input int count);
        logic stepped;
        while (seg_idx < count) begin
            advance_cycle(stepped);
        end
    endtask

    task automatic take_branch(input addr_t target);
        logic stepped;
        branch_i        = 1'b1;
        branch_target_i = target;
        stepped         = 1'b0;
        while (!stepped) begin
            advance_cycle(stepped);
        end
        branch_i = 1'b0;
        walk_ref(target);
        seg_idx = 0;
    endtask

    initial begin
        int cycles;
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk_i);
            cycles++;
        end
        $display("Timeout after %0d cycles with instructions still missing", cycles);
        $display("Something failed");
        $finish;
    end

    initial begin
        int unsigned seed_val;
        seed_val        = $urandom(SEED);
        rst_i           = 1'b0;
        stall_i         = 1'b0;
        branch_i        = 1'b0;
        branch_target_i = '0;
        errors          = 0;
        checked         = 0;
        seg_idx         = 0;
        stall_pct       = 0;
        first_ack_seen  = 1'b0;
        first_read_done = 1'b0;
        fill_program();
        walk_ref(RESET_PC);
        repeat (4) @(posedge clk_i);
        #1;
        rst_i = 1'b1;

        // Through the 32-bit, compressed and mixed regions and then again with stalls
        run_until(100);
        stall_pct = 30;
        run_until(200);

        take_branch(32'h0000_0080);
        run_until(20);
        take_branch(32'h0000_0042);
        run_until(20);
        take_branch(32'h0000_00a2);
        run_until(20);
        take_branch(32'h0000_0010);
        run_until(20);
        take_branch(32'h0000_00c6);
        run_until(20);
        stall_pct = 0;
        take_branch(32'h0000_00a2);
        run_until(20);

        $display("Errors: %0d, instructions checked: %0d", errors, checked);
        if (errors == 0 && checked > 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== tb_fetch_mem.sv ====
module tb_fetch_mem #(
    parameter int DEPTH = 64
) (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        req_i,
    input  logic [29:0] addr_i,
    output logic        ack_o,
    output logic [31:0] data_o
);

    // Program image, written by the testbench before reset ends
    logic [31:0] prog [DEPTH];
    logic        armed;
    logic [1:0]  delay_q;

    initial begin
        ack_o   = 1'b0;
        data_o  = 32'h0;
        armed   = 1'b0;
        delay_q = 2'd0;
    end

    always @(posedge clk_i) begin
        if (!rst_i) begin
            ack_o <= 1'b0;
            armed <= 1'b0;
        end else if (ack_o) begin
            // Release once the request has dropped
            if (!req_i) begin
                ack_o <= 1'b0;
            end
        end else if (req_i) begin
            if (!armed) begin
                delay_q <= 2'($urandom % 4);
                armed   <= 1'b1;
            end else if (delay_q == 2'd0) begin
                ack_o  <= 1'b1;
                data_o <= prog[addr_i % DEPTH];
                armed  <= 1'b0;
            end else begin
                delay_q <= delay_q - 2'd1;
            end
        end
    end

endmodule

// ==== fetch_unit_top.sv ====
module fetch_unit_top (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  stall_i,
    input  logic                  branch_i,
    input  fetch_pkg::addr_t      branch_target_i,
    output logic                  mem_req_o,
    output fetch_pkg::word_addr_t mem_addr_o,
    input  logic                  mem_ack_i,
    input  logic [31:0]           mem_data_i,
    output fetch_pkg::instr_t     instr_o,
    output logic                  instr_valid_o,
    output fetch_pkg::addr_t      pc_o
);

    import fetch_pkg::*;

    // First fetch at byte address 0
    localparam word_addr_t RESET_VECTOR = 30'h0000_0000;

    fetch_ctrl_if ctrl_if ();

    fetch_address_gen #(
        .RESET_VECTOR (RESET_VECTOR)
    ) u_addr_gen (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .stall_i         (stall_i),
        .branch_i        (branch_i),
        .branch_target_i (branch_target_i),
        .ctrl            (ctrl_if.gen),
        .mem_req_o       (mem_req_o),
        .mem_addr_o      (mem_addr_o),
        .mem_ack_i       (mem_ack_i),
        .mem_data_i      (mem_data_i),
        .pc_o            (pc_o)
    );

    // Target bit 1 selects the starting halfword after a branch
    fetch_aligner u_aligner (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .stall_i       (stall_i),
        .branch_i      (branch_i),
        .branch_half_i (branch_target_i[1]),
        .ctrl          (ctrl_if.align),
        .instr_o       (instr_o),
        .instr_valid_o (instr_valid_o)
    );

endmodule

// ==== fetch_address_gen.sv ====
module fetch_address_gen #(
    parameter fetch_pkg::word_addr_t RESET_VECTOR = '0
) (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  stall_i,
    input  logic                  branch_i,
    input  fetch_pkg::addr_t      branch_target_i,
    fetch_ctrl_if.gen             ctrl,
    output logic                  mem_req_o,
    output fetch_pkg::word_addr_t mem_addr_o,
    input  logic                  mem_ack_i,
    input  logic [31:0]           mem_data_i,
    output fetch_pkg::addr_t      pc_o
);

    import fetch_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_ACK,
        WAIT_RELEASE
    } seq_state_t;

    seq_state_t  seq_q;
    logic        read_pending;
    logic        step;
    word_addr_t  counter_q;
    word_addr_t  counter_d;
    logic [31:0] word_q;

    // Busy while a read is queued or the handshake is still open
    assign ctrl.busywait   = read_pending || (seq_q != IDLE);
    assign ctrl.cache_data = word_q;

    assign step = !ctrl.busywait && !stall_i;

    always_comb begin
        if (branch_i) begin
            counter_d = branch_target_i[31:2];
        end else if (ctrl.counter_sel) begin
            counter_d = counter_q + word_addr_t'(1);
        end else begin
            counter_d = counter_q;
        end
    end

    //////////////////////////////
    // Counter and req/ack sequencer
    //////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            seq_q        <= IDLE;
            read_pending <= 1'b1;
            mem_req_o    <= 1'b0;
            mem_addr_o   <= RESET_VECTOR;
            counter_q    <= RESET_VECTOR;
            pc_o         <= {RESET_VECTOR, 2'b00};
        end else begin
            if (step) begin
                counter_q    <= counter_d;
                mem_addr_o   <= counter_d + word_addr_t'(ctrl.address_sel);
                read_pending <= 1'b1;
                pc_o         <= {counter_q, ctrl.half_sel, 1'b0};
            end
            case (seq_q)
                IDLE: begin
                    if (read_pending && !mem_ack_i) begin
                        mem_req_o    <= 1'b1;
                        read_pending <= 1'b0;
                        seq_q        <= WAIT_ACK;
                    end
                end
                WAIT_ACK: begin
                    if (mem_ack_i) begin
                        mem_req_o <= 1'b0;
                        seq_q     <= WAIT_RELEASE;
                    end
                end
                WAIT_RELEASE: begin
                    if (!mem_ack_i) begin
                        seq_q <= IDLE;
                    end
                end
                default: begin
                    seq_q <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (seq_q == WAIT_ACK && mem_ack_i) begin
            word_q <= mem_data_i;
        end
    end

    req_waits_for_release: assert property (
        @(posedge clk_i) disable iff (!rst_i)
        $rose(mem_req_o) |-> !mem_ack_i
    );

    addr_stable_during_req: assert property (
        @(posedge clk_i) disable iff (!rst_i)
        mem_req_o |=> !mem_req_o || $stable(mem_addr_o)
    );

endmodule

// ==== fetch_aligner.sv ====
module fetch_aligner (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              stall_i,
    input  logic              branch_i,
    input  logic              branch_half_i,
    fetch_ctrl_if.align       ctrl,
    output fetch_pkg::instr_t instr_o,
    output logic              instr_valid_o
);

    import fetch_pkg::*;

    align_state_t state_q;
    align_state_t state_d;
    logic         step;
    logic         long_lo;
    logic         long_hi;
    logic [15:2]  saved_hi;
    instr_t       joined;
    parcel_t      decomp_in;
    instr_t       decomp_out;
    instr_t       instr_d;
    logic         valid_d;

    assign step = !ctrl.busywait && !stall_i;

    // Low bits 2'b11 mark a 32-bit instruction
    assign long_lo = &ctrl.cache_data[1:0];
    assign long_hi = &ctrl.cache_data[17:16];

    // Upper half of the previous word joined with the lower half of this one
    assign joined = {ctrl.cache_data[15:0], saved_hi};

    assign decomp_in = (state_q == UPPER) ? ctrl.cache_data[31:16] : ctrl.cache_data[15:0];

    instr_decompressor u_decompressor (
        .parcel_i (decomp_in),
        .instr_o  (decomp_out)
    );

    //////////////////////////////
    // Next state and selects
    //////////////////////////////

    always_comb begin
        state_d          = state_q;
        instr_d          = INSTR_BUBBLE;
        valid_d          = 1'b0;
        ctrl.counter_sel = 1'b0;
        if (branch_i) begin
            state_d = branch_half_i ? UPPER : LOWER;
        end else begin
            case (state_q)
                LOWER: begin
                    valid_d = 1'b1;
                    if (long_lo) begin
                        instr_d          = ctrl.cache_data[31:2];
                        ctrl.counter_sel = 1'b1;
                    end else begin
                        instr_d = decomp_out;
                        state_d = long_hi ? STRADDLE : UPPER;
                    end
                end
                UPPER: begin
                    if (long_hi) begin
                        // Only after a branch, wait for the second half
                        state_d = STRADDLE;
                    end else begin
                        instr_d          = decomp_out;
                        valid_d          = 1'b1;
                        ctrl.counter_sel = 1'b1;
                        state_d          = LOWER;
                    end
                end
                STRADDLE: begin
                    instr_d          = joined;
                    valid_d          = 1'b1;
                    ctrl.counter_sel = 1'b1;
                    state_d          = long_hi ? STRADDLE : UPPER;
                end
                default: begin
                    state_d = LOWER;
                end
            endcase
        end
    end

    // A straddle needs the word after the counter
    assign ctrl.address_sel = (state_d == STRADDLE);
    assign ctrl.half_sel    = (state_q != LOWER);

    //////////////////////////////
    // Registers
    //////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q       <= LOWER;
            instr_o       <= INSTR_BUBBLE;
            instr_valid_o <= 1'b0;
        end else if (step) begin
            state_q       <= state_d;
            instr_o       <= instr_d;
            instr_valid_o <= valid_d;
        end else begin
            instr_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (step) begin
            saved_hi <= ctrl.cache_data[31:18];
        end
    end

    // Compressed upper parcel after a straddle is read again from the same word
    straddle_compressed_no_skip: assert property (
        @(posedge clk_i) disable iff (!rst_i)
        step && state_q == STRADDLE && !long_hi |-> !(ctrl.counter_sel && ctrl.address_sel)
    );

endmodule

// ==== instr_decompressor.sv ====
module instr_decompressor (
    input  fetch_pkg::parcel_t parcel_i,
    output fetch_pkg::instr_t  instr_o
);

    // Opcode bits 6:2 of the RV32I targets
    localparam logic [4:0] OPC_OP_IMM = 5'b00100;
    localparam logic [4:0] OPC_LUI    = 5'b01101;
    localparam logic [4:0] OPC_OP     = 5'b01100;

    logic [1:0]  quadrant;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [4:0]  rs2;
    logic        imm_sign;
    logic [11:0] imm_ci;
    logic [19:0] imm_lui;

    //////////////////////////////
    // Parcel fields
    //////////////////////////////

    assign quadrant = parcel_i[1:0];
    assign funct3   = parcel_i[15:13];
    assign rd       = parcel_i[11:7];
    assign rs2      = parcel_i[6:2];
    assign imm_sign = parcel_i[12];

    // CI immediate, six bits with the sign in parcel bit 12
    assign imm_ci  = {{6{imm_sign}}, imm_sign, parcel_i[6:2]};
    assign imm_lui = {{14{imm_sign}}, imm_sign, parcel_i[6:2]};

    //////////////////////////////
    // Expansion
    //////////////////////////////

    always_comb begin
        // Anything outside the subset becomes the illegal pattern
        instr_o = '0;
        case (quadrant)
            2'b01: begin
                case (funct3)
                    // C.ADDI, C.NOP is the rd = 0, imm = 0 case
                    3'b000: begin
                        instr_o = {imm_ci, rd, 3'b000, rd, OPC_OP_IMM};
                    end
                    // C.LI
                    3'b010: begin
                        instr_o = {imm_ci, 5'd0, 3'b000, rd, OPC_OP_IMM};
                    end
                    // C.LUI, rd = 2 is C.ADDI16SP and zero imm is reserved
                    3'b011: begin
                        if (rd != 5'd2 && imm_ci != 12'd0) begin
                            instr_o = {imm_lui, rd, OPC_LUI};
                        end
                    end
                    default: begin
                        instr_o = '0;
                    end
                endcase
            end
            2'b10: begin
                // rs2 = 0 would be C.JR, C.JALR or C.EBREAK
                if (funct3 == 3'b100 && rs2 != 5'd0) begin
                    if (parcel_i[12]) begin
                        // C.ADD
                        instr_o = {7'd0, rs2, rd, 3'b000, rd, OPC_OP};
                    end else begin
                        // C.MV
                        instr_o = {7'd0, rs2, 5'd0, 3'b000, rd, OPC_OP};
                    end
                end
            end
            default: begin
                instr_o = '0;
            end
        endcase
    end

endmodule

// ==== fetch_ctrl_if.sv ====
interface fetch_ctrl_if;

    // Word latched from memory, valid while busywait is low
    logic [31:0] cache_data;
    logic        busywait;

    // Selects from the aligner, used by the generator on a step
    logic        counter_sel;
    logic        address_sel;
    logic        half_sel;

    modport gen (
        output cache_data,
        output busywait,
        input  counter_sel,
        input  address_sel,
        input  half_sel
    );

    modport align (
        input  cache_data,
        input  busywait,
        output counter_sel,
        output address_sel,
        output half_sel
    );

endinterface

// ==== fetch_pkg.sv ====
package fetch_pkg;

    //////////////////////////////
    // Address and data widths
    //////////////////////////////

    // Full byte address
    typedef logic [31:0] addr_t;

    // Word address, byte address bits 31:2
    typedef logic [29:0] word_addr_t;

    // One 16-bit instruction parcel
    typedef logic [15:0] parcel_t;

    // Instruction bits 31:2
    // Low two bits of a 32-bit instruction are always 2'b11
    typedef logic [29:0] instr_t;

    //////////////////////////////
    // Constants
    //////////////////////////////

    // ADDI x0, x0, 0 without its low opcode bits
    localparam instr_t INSTR_BUBBLE = 30'h0000_0004;

    //////////////////////////////
    // Aligner state
    //////////////////////////////

    // Where the next instruction starts, relative to the fetch counter
    typedef enum logic [1:0] {
        LOWER,
        UPPER,
        STRADDLE
    } align_state_t;

endpackage
